// ==== files.f ====
+incdir+.
rv_decode_pkg.sv
rv_op_classifier.sv
rv_imm_gen.sv
rv_target_gen.sv
rv_decode_top.sv
tb_rv_decode.sv

// ==== rv_decode_model.svh ====
// Decode reference model
`ifndef RV_DECODE_MODEL_SVH
`define RV_DECODE_MODEL_SVH

// Encoders take a plain immediate value and scatter its bits into the word
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] val, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {val, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] val, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [6:0] opc);
    return {val[11:5], rs2, rs1, f3, val[4:0], opc};
endfunction

// Byte offset whose bit 0 is dropped
function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] val, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {val, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

// Expected immediate from the value given to the encoder
function automatic logic [31:0] expect_imm(input logic [FMT_W-1:0] f,
                                           input logic [31:0] raw);
    case (f)
        FMT_I, FMT_S: return {{20{raw[11]}}, raw[11:0]};
        FMT_B:        return {{19{raw[12]}}, raw[12:1], 1'b0};
        FMT_U:        return {raw[19:0], 12'b0};
        FMT_J:        return {{11{raw[20]}}, raw[20:1], 1'b0};
        default:      return '0; // No immediate in R format
    endcase
endfunction

// Only branch and JAL words jump relative to their own pc
function automatic logic [31:0] expect_target(input logic [FMT_W-1:0] f,
                                              input logic [31:0] at_pc,
                                              input logic [31:0] offset);
    if (f == FMT_B || f == FMT_J)
        return at_pc + offset;
    return at_pc + 32'd4;
endfunction

`endif

// ==== tb_rv_decode.sv ====
// Decode unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode import rv_decode_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 400;

    logic                 clk;
    logic                 arst_n;
    logic                 in_valid;
    rv_instr_u            instr;
    logic [XLEN-1:0]      pc;
    logic                 out_valid;
    logic [OP_W-1:0]      op;
    logic [FMT_W-1:0]     fmt;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      target;
    logic [RM_W-1:0]      rm;
    logic                 illegal;

    logic [31:0]          rng_state = 32'h14c5384b;
    int                   cycles = 0;
    logic [REG_IDX_W-1:0] cur_rs1; // Register fields of the word being built
    logic [REG_IDX_W-1:0] cur_rs2;
    logic [REG_IDX_W-1:0] cur_rd;

    `include "rv_decode_model.svh"

    rv_decode_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            fail_run($sformatf("Timeout: the run did not finish in %0d cycles", TIMEOUT_CYCLES));
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [31:0] random_pc();
        logic [31:0] r;
        r = next_rand();
        return {r[31:2], 2'b00}; // Word aligned
    endfunction

    task automatic pick_regs();
        logic [31:0] r;
        r       = next_rand();
        cur_rs1 = r[4:0];
        cur_rs2 = r[9:5];
        cur_rd  = r[14:10];
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("** Error at %0d ns: %s is %0h, expected %0h",
                                $time, name, got, exp));
    endtask

    task automatic check_result(input logic [OP_W-1:0] e_op, input logic [FMT_W-1:0] e_fmt,
                                input logic [31:0] raw, input logic [RM_W-1:0] e_rm,
                                input logic [31:0] word_pc, input logic [4:0] e_rs1,
                                input logic [4:0] e_rs2, input logic [4:0] e_rd);
        logic [31:0] e_imm;
        logic        bad;
        bad = (e_op == OP_ILLEGAL);
        if (bad) begin // Unknown words look like R format with no rounding mode
            e_fmt = FMT_R;
            e_rm  = '0;
        end
        e_imm = expect_imm(e_fmt, raw);
        check_field("op", op, e_op);
        check_field("fmt", fmt, e_fmt);
        check_field("illegal", illegal, bad);
        check_field("imm", imm, e_imm);
        check_field("target", target, expect_target(e_fmt, word_pc, e_imm));
        check_field("rm", rm, e_rm);
        if (!bad && e_fmt != FMT_U && e_fmt != FMT_J)
            check_field("rs1", rs1, e_rs1);
        if (!bad && (e_fmt == FMT_R || e_fmt == FMT_S || e_fmt == FMT_B))
            check_field("rs2", rs2, e_rs2);
        if (!bad && e_fmt != FMT_S && e_fmt != FMT_B)
            check_field("rd", rd, e_rd);
    endtask

    task automatic strobe_word(input logic [31:0] word, input logic [31:0] word_pc);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        instr    = word;
        pc       = word_pc;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (!out_valid) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_word(input logic [31:0] word, input logic [OP_W-1:0] e_op,
                            input logic [FMT_W-1:0] e_fmt, input logic [31:0] raw,
                            input logic [RM_W-1:0] e_rm);
        logic [31:0] word_pc;
        word_pc = random_pc();
        strobe_word(word, word_pc);
        check_result(e_op, e_fmt, raw, e_rm, word_pc, cur_rs1, cur_rs2, cur_rd);
    endtask

    task automatic random_legal(output logic [31:0] word, output logic [OP_W-1:0] w_op,
                                output logic [FMT_W-1:0] w_fmt, output logic [31:0] raw);
        logic [OP_W-1:0]  ops  [8];
        logic [FMT_W-1:0] fmts [8];
        logic [31:0]      pick;
        ops  = '{OP_ADD, OP_SUB, OP_ADDI, OP_LW, OP_SW, OP_BEQ, OP_LUI, OP_JAL};
        fmts = '{FMT_R, FMT_R, FMT_I, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J};
        pick_regs();
        pick = next_rand();
        raw  = next_rand();
        case (pick[2:0])
            3'd0: word = enc_r(F7_BASE, cur_rs2, cur_rs1, 3'b000, cur_rd, OPC_OP);
            3'd1: word = enc_r(F7_ALT, cur_rs2, cur_rs1, 3'b000, cur_rd, OPC_OP);
            3'd2: word = enc_i(raw[11:0], cur_rs1, 3'b000, cur_rd, OPC_OP_IMM);
            3'd3: word = enc_i(raw[11:0], cur_rs1, 3'b010, cur_rd, OPC_LOAD);
            3'd4: word = enc_s(raw[11:0], cur_rs2, cur_rs1, 3'b010, OPC_STORE);
            3'd5: word = enc_b(raw[12:0], cur_rs2, cur_rs1, 3'b000);
            3'd6: word = enc_u(raw[19:0], cur_rd, OPC_LUI);
            default: word = enc_j(raw[20:0], cur_rd);
        endcase
        w_op  = ops[pick[2:0]];
        w_fmt = fmts[pick[2:0]];
    endtask

    task automatic test_reset_state();
        check_field("out_valid", out_valid, 0);
        check_field("illegal", illegal, 0);
        check_field("imm", imm, 0);
        check_field("target", target, 0);
    endtask

    task automatic test_base_ops();
        logic [OP_W-1:0] r_ops  [8];
        logic [OP_W-1:0] i_ops  [8];
        logic [OP_W-1:0] ld_ops [8];
        logic [OP_W-1:0] st_ops [8];
        logic [OP_W-1:0] br_ops [8];
        logic [31:0]     raw;
        logic [3:0]      f3;
        r_ops  = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_OR, OP_AND};
        i_ops  = '{OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI, OP_SRLI, OP_ORI, OP_ANDI};
        ld_ops = '{OP_LB, OP_LH, OP_LW, OP_ILLEGAL, OP_LBU, OP_LHU, OP_ILLEGAL, OP_ILLEGAL};
        st_ops = '{OP_SB, OP_SH, OP_SW, OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL,
                   OP_ILLEGAL};
        br_ops = '{OP_BEQ, OP_BNE, OP_ILLEGAL, OP_ILLEGAL, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        for (f3 = 0; f3 < 8; f3++) begin
            pick_regs();
            raw = next_rand();
            run_word(enc_r(F7_BASE, cur_rs2, cur_rs1, f3[2:0], cur_rd, OPC_OP),
                     r_ops[f3], FMT_R, 0, 0);
            if (f3 == 1 || f3 == 5)
                raw[11:5] = F7_BASE; // Plain shifts
            run_word(enc_i(raw[11:0], cur_rs1, f3[2:0], cur_rd, OPC_OP_IMM),
                     i_ops[f3], FMT_I, raw, 0);
            run_word(enc_i(raw[11:0], cur_rs1, f3[2:0], cur_rd, OPC_LOAD),
                     ld_ops[f3], FMT_I, raw, 0);
            run_word(enc_s(raw[11:0], cur_rs2, cur_rs1, f3[2:0], OPC_STORE),
                     st_ops[f3], FMT_S, raw, 0);
            run_word(enc_b(raw[12:0], cur_rs2, cur_rs1, f3[2:0]), br_ops[f3], FMT_B, raw, 0);
        end
        pick_regs();
        raw = next_rand();
        run_word(enc_r(F7_ALT, cur_rs2, cur_rs1, 3'b000, cur_rd, OPC_OP), OP_SUB, FMT_R, 0, 0);
        run_word(enc_r(F7_ALT, cur_rs2, cur_rs1, 3'b101, cur_rd, OPC_OP), OP_SRA, FMT_R, 0, 0);
        run_word(enc_u(raw[19:0], cur_rd, OPC_LUI), OP_LUI, FMT_U, raw, 0);
        run_word(enc_j(raw[20:0], cur_rd), OP_JAL, FMT_J, raw, 0);
        run_word(enc_i(raw[11:0], cur_rs1, 3'b000, cur_rd, OPC_JALR), OP_JALR, FMT_I, raw, 0);
        raw[11:5] = F7_ALT;
        run_word(enc_i(raw[11:0], cur_rs1, 3'b101, cur_rd, OPC_OP_IMM), OP_SRAI, FMT_I, raw, 0);
    endtask

    task automatic test_immediates();
        logic [31:0] raw;
        logic [1:0]  sign;
        for (sign = 0; sign < 2; sign++) begin
            pick_regs();
            raw     = next_rand();
            raw[11] = sign[0];
            run_word(enc_i(raw[11:0], cur_rs1, 3'b000, cur_rd, OPC_OP_IMM),
                     OP_ADDI, FMT_I, raw, 0);
            run_word(enc_s(raw[11:0], cur_rs2, cur_rs1, 3'b010, OPC_STORE),
                     OP_SW, FMT_S, raw, 0);
            raw[12] = sign[0];
            run_word(enc_b(raw[12:0], cur_rs2, cur_rs1, 3'b001), OP_BNE, FMT_B, raw, 0);
            raw[19] = sign[0];
            run_word(enc_u(raw[19:0], cur_rd, OPC_LUI), OP_LUI, FMT_U, raw, 0);
            raw[20] = sign[0];
            run_word(enc_j(raw[20:0], cur_rd), OP_JAL, FMT_J, raw, 0);
        end
    endtask

    task automatic test_ext_ops();
        logic [OP_W-1:0] md_ops [8];
        logic [OP_W-1:0] fp_ops [4];
        logic [6:0]      fp_f7  [4];
        logic [31:0]     raw;
        logic [3:0]      k;
        md_ops = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        fp_ops = '{OP_FADD, OP_FSUB, OP_FMUL, OP_FDIV};
        fp_f7  = '{F7_FADD, F7_FSUB, F7_FMUL, F7_FDIV};
        for (k = 0; k < 8; k++) begin
            pick_regs();
            run_word(enc_r(F7_MULDIV, cur_rs2, cur_rs1, k[2:0], cur_rd, OPC_OP),
                     md_ops[k], FMT_R, 0, 0);
        end
        for (k = 0; k < 4; k++) begin
            pick_regs();
            raw = next_rand(); // Random rounding mode
            run_word(enc_r(fp_f7[k], cur_rs2, cur_rs1, raw[2:0], cur_rd, OPC_OP_FP),
                     fp_ops[k], FMT_R, 0, raw[2:0]);
        end
        pick_regs();
        cur_rs2 = '0;
        raw     = next_rand();
        run_word(enc_r(F7_FSQRT, cur_rs2, cur_rs1, raw[2:0], cur_rd, OPC_OP_FP),
                 OP_FSQRT, FMT_R, 0, raw[2:0]);
        pick_regs();
        run_word(enc_i(raw[11:0], cur_rs1, 3'b010, cur_rd, OPC_LOAD_FP), OP_FLW, FMT_I, raw, 0);
        run_word(enc_s(raw[11:0], cur_rs2, cur_rs1, 3'b010, OPC_STORE_FP),
                 OP_FSW, FMT_S, raw, 0);
    endtask

    task automatic test_illegal();
        logic [31:0] bad_words [9];
        logic [31:0] r;
        int          k;
        pick_regs();
        r = next_rand();
        bad_words[0] = enc_r(r[6:0], cur_rs2, cur_rs1, r[9:7], cur_rd, 7'b1111111);
        bad_words[1] = enc_r(r[6:0], cur_rs2, cur_rs1, r[9:7], cur_rd, 7'b0001011);
        bad_words[2] = enc_r(7'b0000010, cur_rs2, cur_rs1, 3'b000, cur_rd, OPC_OP);
        bad_words[3] = enc_r(F7_ALT, cur_rs2, cur_rs1, 3'b001, cur_rd, OPC_OP);
        bad_words[4] = enc_r(F7_ALT, cur_rs2, cur_rs1, 3'b001, cur_rd, OPC_OP_IMM);
        bad_words[5] = enc_r(7'b1111111, cur_rs2, cur_rs1, 3'b111, cur_rd, OPC_OP_FP);
        bad_words[6] = enc_r(F7_FSQRT, cur_rs2 | 5'd1, cur_rs1, 3'b000, cur_rd, OPC_OP_FP);
        bad_words[7] = enc_r(r[6:0], cur_rs2, cur_rs1, 3'b011, cur_rd, OPC_LOAD_FP);
        bad_words[8] = enc_r(r[6:0], cur_rs2, cur_rs1, 3'b001, cur_rd, OPC_JALR);
        for (k = 0; k < 9; k++)
            run_word(bad_words[k], OP_ILLEGAL, FMT_R, 0, 0);
    endtask

    task automatic test_stream();
        logic [31:0]          s_pc  [20];
        logic [31:0]          s_raw [20];
        logic [OP_W-1:0]      s_op  [20];
        logic [FMT_W-1:0]     s_fmt [20];
        logic [REG_IDX_W-1:0] s_rs1 [20];
        logic [REG_IDX_W-1:0] s_rs2 [20];
        logic [REG_IDX_W-1:0] s_rd  [20];
        logic [31:0]          word;
        int                   i;
        for (i = 0; i <= 20; i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin // Word strobed one cycle earlier
                check_field("out_valid", out_valid, 1);
                check_result(s_op[i-1], s_fmt[i-1], s_raw[i-1], '0, s_pc[i-1],
                             s_rs1[i-1], s_rs2[i-1], s_rd[i-1]);
            end
            if (i < 20) begin
                random_legal(word, s_op[i], s_fmt[i], s_raw[i]);
                s_rs1[i] = cur_rs1;
                s_rs2[i] = cur_rs2;
                s_rd[i]  = cur_rd;
                s_pc[i]  = random_pc();
                in_valid = 1'b1;
                instr    = word;
                pc       = s_pc[i];
            end else begin
                in_valid = 1'b0;
                instr    = '1; // Illegal word left on the bus while idle
                pc       = ~s_pc[19];
            end
        end
        repeat (2) begin // Idle cycles hold the last result
            @(posedge clk);
            #1;
            check_field("out_valid", out_valid, 0);
            check_result(s_op[19], s_fmt[19], s_raw[19], '0, s_pc[19],
                         s_rs1[19], s_rs2[19], s_rd[19]);
        end
        random_legal(word, s_op[0], s_fmt[0], s_raw[0]);
        run_word(word, s_op[0], s_fmt[0], s_raw[0], '0);
    endtask

    initial begin
        arst_n   = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        pc       = '0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
        test_reset_state();
        test_base_ops();
        test_immediates();
        test_ext_ops();
        test_illegal();
        test_stream();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_decode_top.sv ====
// RISC-V instruction decode unit
`timescale 1ns/1ps
`default_nettype none

module rv_decode_top import rv_decode_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  rv_instr_u            instr,
    input  logic [XLEN-1:0]      pc,
    output logic                 out_valid,
    output logic [OP_W-1:0]      op,
    output logic [FMT_W-1:0]     fmt,
    output logic [REG_IDX_W-1:0] rs1,
    output logic [REG_IDX_W-1:0] rs2,
    output logic [REG_IDX_W-1:0] rd,
    output logic [XLEN-1:0]      imm,
    output logic [XLEN-1:0]      target,
    output logic [RM_W-1:0]      rm,
    output logic                 illegal
);

    logic [FMT_W-1:0] imm_fmt;  // Unregistered format of the incoming word
    logic             is_jump;
    logic [XLEN-1:0]  next_imm;

    rv_op_classifier u_classifier (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .imm_fmt   (imm_fmt),
        .is_jump   (is_jump),
        .out_valid (out_valid),
        .op        (op),
        .fmt       (fmt),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .rm        (rm),
        .illegal   (illegal)
    );

    rv_imm_gen u_imm_gen (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .instr    (instr),
        .imm_fmt  (imm_fmt),
        .next_imm (next_imm),
        .imm      (imm)
    );

    // Same edge as the classifier, so target lines up with out_valid
    rv_target_gen u_target_gen (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .pc       (pc),
        .next_imm (next_imm),
        .is_jump  (is_jump),
        .target   (target)
    );

endmodule

`default_nettype wire

// ==== rv_target_gen.sv ====
// Control-flow target generator
`timescale 1ns/1ps
`default_nettype none

module rv_target_gen import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] next_imm,
    input  logic            is_jump,
    output logic [XLEN-1:0] target
);

    logic [XLEN-1:0] pc_plus_imm;
    logic [XLEN-1:0] pc_plus_4;

    // Branch and JAL offsets are relative to the word's own pc
    assign pc_plus_imm = pc + next_imm;

    // Fall-through, also the JALR link value
    assign pc_plus_4 = pc + XLEN'(4);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            target <= '0;
        end else if (in_valid) begin
            target <= is_jump ? pc_plus_imm : pc_plus_4;
        end
    end

endmodule

`default_nettype wire

// ==== rv_imm_gen.sv ====
// Immediate generator
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen import rv_decode_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    input  rv_instr_u        instr,
    input  logic [FMT_W-1:0] imm_fmt,
    output logic [XLEN-1:0]  next_imm,
    output logic [XLEN-1:0]  imm
);

    // Sign bit is always instruction bit 31
    always_comb begin
        case (imm_fmt)
            FMT_I: next_imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            FMT_S: next_imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            FMT_B: begin
                next_imm = {{20{instr.b.imm12}},
                            instr.b.imm11,
                            instr.b.imm10_5,
                            instr.b.imm4_1,
                            1'b0}; // Halfword aligned
            end
            FMT_U: next_imm = {instr.u.imm, 12'b0};
            FMT_J: begin
                next_imm = {{12{instr.j.imm20}},
                            instr.j.imm19_12,
                            instr.j.imm11,
                            instr.j.imm10_1,
                            1'b0};
            end
            default: next_imm = '0; // R format has no immediate
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            imm <= '0;
        end else if (in_valid) begin
            imm <= next_imm;
        end
    end

endmodule

`default_nettype wire

// ==== rv_op_classifier.sv ====
// Opcode classifier
`timescale 1ns/1ps
`default_nettype none

module rv_op_classifier import rv_decode_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  rv_instr_u            instr,
    output logic [FMT_W-1:0]     imm_fmt,
    output logic                 is_jump,
    output logic                 out_valid,
    output logic [OP_W-1:0]      op,
    output logic [FMT_W-1:0]     fmt,
    output logic [REG_IDX_W-1:0] rs1,
    output logic [REG_IDX_W-1:0] rs2,
    output logic [REG_IDX_W-1:0] rd,
    output logic [RM_W-1:0]      rm,
    output logic                 illegal
);

    logic [OP_W-1:0]  dec_op;
    logic [FMT_W-1:0] dec_fmt;
    logic             dec_jump;
    logic [RM_W-1:0]  dec_rm;
    logic             dec_illegal;

    always_comb begin
        dec_op   = OP_ILLEGAL; // Anything not matched below
        dec_fmt  = FMT_R;
        dec_jump = 1'b0;
        dec_rm   = '0;
        case (instr.r.opcode)
            OPC_OP: begin
                case (instr.r.funct7)
                    F7_BASE: begin
                        case (instr.r.funct3)
                            3'b000: dec_op = OP_ADD;
                            3'b001: dec_op = OP_SLL;
                            3'b010: dec_op = OP_SLT;
                            3'b011: dec_op = OP_SLTU;
                            3'b100: dec_op = OP_XOR;
                            3'b101: dec_op = OP_SRL;
                            3'b110: dec_op = OP_OR;
                            3'b111: dec_op = OP_AND;
                        endcase
                    end
                    F7_ALT: begin
                        if (instr.r.funct3 == 3'b000)
                            dec_op = OP_SUB;
                        else if (instr.r.funct3 == 3'b101)
                            dec_op = OP_SRA;
                    end
                    F7_MULDIV: begin
                        case (instr.r.funct3)
                            3'b000: dec_op = OP_MUL;
                            3'b001: dec_op = OP_MULH;
                            3'b010: dec_op = OP_MULHSU;
                            3'b011: dec_op = OP_MULHU;
                            3'b100: dec_op = OP_DIV;
                            3'b101: dec_op = OP_DIVU;
                            3'b110: dec_op = OP_REM;
                            3'b111: dec_op = OP_REMU;
                        endcase
                    end
                    default: ;
                endcase
            end
            OPC_OP_IMM: begin
                dec_fmt = FMT_I;
                case (instr.r.funct3)
                    3'b000: dec_op = OP_ADDI;
                    3'b010: dec_op = OP_SLTI;
                    3'b011: dec_op = OP_SLTIU;
                    3'b100: dec_op = OP_XORI;
                    3'b110: dec_op = OP_ORI;
                    3'b111: dec_op = OP_ANDI;
                    3'b001: if (instr.r.funct7 == F7_BASE) dec_op = OP_SLLI;
                    3'b101: begin // Shift type sits in the upper immediate bits
                        if (instr.r.funct7 == F7_BASE)
                            dec_op = OP_SRLI;
                        else if (instr.r.funct7 == F7_ALT)
                            dec_op = OP_SRAI;
                    end
                endcase
            end
            OPC_LOAD: begin
                dec_fmt = FMT_I;
                case (instr.r.funct3)
                    3'b000: dec_op = OP_LB;
                    3'b001: dec_op = OP_LH;
                    3'b010: dec_op = OP_LW;
                    3'b100: dec_op = OP_LBU;
                    3'b101: dec_op = OP_LHU;
                    default: ;
                endcase
            end
            OPC_LOAD_FP: begin
                dec_fmt = FMT_I;
                if (instr.r.funct3 == 3'b010) dec_op = OP_FLW; // Word width only
            end
            OPC_STORE: begin
                dec_fmt = FMT_S;
                case (instr.r.funct3)
                    3'b000: dec_op = OP_SB;
                    3'b001: dec_op = OP_SH;
                    3'b010: dec_op = OP_SW;
                    default: ;
                endcase
            end
            OPC_STORE_FP: begin
                dec_fmt = FMT_S;
                if (instr.r.funct3 == 3'b010) dec_op = OP_FSW;
            end
            OPC_BRANCH: begin
                dec_fmt  = FMT_B;
                dec_jump = 1'b1;
                case (instr.r.funct3)
                    3'b000: dec_op = OP_BEQ;
                    3'b001: dec_op = OP_BNE;
                    3'b100: dec_op = OP_BLT;
                    3'b101: dec_op = OP_BGE;
                    3'b110: dec_op = OP_BLTU;
                    3'b111: dec_op = OP_BGEU;
                    default: ;
                endcase
            end
            OPC_LUI: begin
                dec_fmt = FMT_U;
                dec_op  = OP_LUI;
            end
            OPC_JAL: begin
                dec_fmt  = FMT_J;
                dec_jump = 1'b1;
                dec_op   = OP_JAL;
            end
            OPC_JALR: begin
                dec_fmt = FMT_I; // Target resolved in execute
                if (instr.r.funct3 == 3'b000) dec_op = OP_JALR;
            end
            OPC_OP_FP: begin
                dec_rm = instr.r.funct3; // Rounding mode field
                case (instr.r.funct7)
                    F7_FADD:  dec_op = OP_FADD;
                    F7_FSUB:  dec_op = OP_FSUB;
                    F7_FMUL:  dec_op = OP_FMUL;
                    F7_FDIV:  dec_op = OP_FDIV;
                    F7_FSQRT: if (instr.r.rs2 == '0) dec_op = OP_FSQRT;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // Illegal words look like R format so no immediate or jump leaks out
    assign dec_illegal = (dec_op == OP_ILLEGAL);
    assign imm_fmt     = dec_illegal ? FMT_R : dec_fmt;
    assign is_jump     = dec_jump & ~dec_illegal;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            op        <= OP_ILLEGAL;
            fmt       <= FMT_R;
            rs1       <= '0;
            rs2       <= '0;
            rd        <= '0;
            rm        <= '0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                op      <= dec_op;
                fmt     <= imm_fmt;
                rs1     <= instr.r.rs1;
                rs2     <= instr.r.rs2;
                rd      <= instr.r.rd;
                rm      <= dec_illegal ? '0 : dec_rm;
                illegal <= dec_illegal;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rv_decode_pkg.sv ====
// RISC-V decode definitions
`default_nettype none

package rv_decode_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int OP_W      = 6;
    localparam int FMT_W     = 3;
    localparam int RM_W      = 3;

    // Major opcodes
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_OP_FP    = 7'b1010011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // SUB, SRA, SRAI
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // Single-precision arithmetic
    localparam logic [6:0] F7_FADD  = 7'b0000000;
    localparam logic [6:0] F7_FSUB  = 7'b0000100;
    localparam logic [6:0] F7_FMUL  = 7'b0001000;
    localparam logic [6:0] F7_FDIV  = 7'b0001100;
    localparam logic [6:0] F7_FSQRT = 7'b0101100;

    // Immediate layout and meaningful register fields
    localparam logic [FMT_W-1:0] FMT_R = 3'd0;
    localparam logic [FMT_W-1:0] FMT_I = 3'd1;
    localparam logic [FMT_W-1:0] FMT_S = 3'd2;
    localparam logic [FMT_W-1:0] FMT_B = 3'd3;
    localparam logic [FMT_W-1:0] FMT_U = 3'd4;
    localparam logic [FMT_W-1:0] FMT_J = 3'd5;

    localparam logic [OP_W-1:0] OP_ILLEGAL = 6'd0;
    localparam logic [OP_W-1:0] // Register-register
        OP_ADD  = 6'd1,  OP_SUB  = 6'd2,  OP_SLL  = 6'd3,  OP_SLT = 6'd4,  OP_SLTU = 6'd5,
        OP_XOR  = 6'd6,  OP_SRL  = 6'd7,  OP_SRA  = 6'd8,  OP_OR  = 6'd9,  OP_AND  = 6'd10;
    localparam logic [OP_W-1:0] // Register-immediate
        OP_ADDI = 6'd11, OP_SLTI = 6'd12, OP_SLTIU = 6'd13, OP_XORI = 6'd14, OP_ORI = 6'd15,
        OP_ANDI = 6'd16, OP_SLLI = 6'd17, OP_SRLI  = 6'd18, OP_SRAI = 6'd19;
    localparam logic [OP_W-1:0] // Loads and stores
        OP_LB = 6'd20, OP_LH = 6'd21, OP_LW = 6'd22, OP_LBU = 6'd23, OP_LHU = 6'd24,
        OP_SB = 6'd25, OP_SH = 6'd26, OP_SW = 6'd27;
    localparam logic [OP_W-1:0] // Control flow and upper immediate
        OP_BEQ  = 6'd28, OP_BNE  = 6'd29, OP_BLT  = 6'd30, OP_BGE = 6'd31, OP_BLTU = 6'd32,
        OP_BGEU = 6'd33, OP_LUI  = 6'd34, OP_JAL  = 6'd35, OP_JALR = 6'd36;
    localparam logic [OP_W-1:0] // Multiply and divide
        OP_MUL = 6'd37, OP_MULH = 6'd38, OP_MULHSU = 6'd39, OP_MULHU = 6'd40,
        OP_DIV = 6'd41, OP_DIVU = 6'd42, OP_REM    = 6'd43, OP_REMU  = 6'd44;
    localparam logic [OP_W-1:0] // Floating point
        OP_FLW  = 6'd45, OP_FSW  = 6'd46, OP_FADD = 6'd47, OP_FSUB = 6'd48,
        OP_FMUL = 6'd49, OP_FDIV = 6'd50, OP_FSQRT = 6'd51;

    // One instruction word, six encodings
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_instr_u;

endpackage

`default_nettype wire
